// File: verilog.f
src/jacobian_pkg.sv
src/cordic_sincos.sv
src/link_phase_unit.sv
src/term_fifo.sv
src/jacobian_accumulator.sv
src/planar_jacobian_top.sv
verification/clk_gen.sv
verification/jacobian_tb.sv

// File: Bender.yml
package:
  name: planar_jacobian

sources:
  # design, package first
  - src/jacobian_pkg.sv
  - src/cordic_sincos.sv
  - src/link_phase_unit.sv
  - src/term_fifo.sv
  - src/jacobian_accumulator.sv
  - src/planar_jacobian_top.sv

  # testbench
  - target: test
    files:
      - verification/clk_gen.sv
      - verification/jacobian_tb.sv

// File: verification/jacobian_tb.sv
//----------------------------------------------------------------------------
// jacobian testbench with stimulus, integer model, assertions and timeout
//----------------------------------------------------------------------------
`default_nettype none

module jacobian_tb;

	import jacobian_pkg::*;

	localparam int NJ             = 3;
	localparam int NUM_JOBS       = 16;
	localparam int ITERS          = 14;
	localparam int GAIN_INV       = 9949;               // 0.60725 in Q1.14
	localparam int TIMEOUT_CYCLES = NUM_JOBS * (NJ * (ITERS + 6) + 20);
	localparam int ATAN_REF [ITERS] = '{8192, 4836, 2555, 1297, 651, 326, 163,
		81, 41, 20, 10, 5, 3, 1};

	logic                 clk;
	logic                 rst_n;
	logic                 start;
	angle_t  [NJ-1:0]     theta;
	length_t [NJ-1:0]     link_len;
	logic                 busy;
	logic                 col_valid;
	logic                 done;
	jac_col_t             col;
	jac_col_t             exp_mem [256]; // expected columns in emit order
	jac_col_t             exp_head;
	logic [7:0]           rd_ptr;
	logic [7:0]           wr_ptr;
	logic                 started;
	int                   cycles = 0;
	integer               seed;

	clk_gen #(.PERIOD (8)) u_clk (.clk (clk));

	planar_jacobian_top #(
		.NUM_JOINTS (NJ),
		.FIFO_DEPTH (2)
	) u_dut (
		.clk       (clk),
		.rst_n     (rst_n),
		.start     (start),
		.theta     (theta),
		.link_len  (link_len),
		.busy      (busy),
		.col_valid (col_valid),
		.col       (col),
		.done      (done)
	);

	assign exp_head = exp_mem[rd_ptr];

	always @(posedge clk or negedge rst_n) begin
		if (!rst_n)
			rd_ptr <= '0;
		else if (col_valid)
			rd_ptr <= rd_ptr + 1'b1; // one expected column consumed
	end

	always @(posedge clk) begin
		cycles <= cycles + 1;
		if (cycles >= TIMEOUT_CYCLES) begin
			$display("timeout: jobs did not finish within %0d cycles", TIMEOUT_CYCLES);
			$display("FAIL: see errors above");
			$fatal(1, "run stopped by timeout");
		end
	end

	task automatic report_error(input string msg);
		$display("Error at %0t: %s", $time, msg);
		$display("FAIL: see errors above");
		$fatal(1, "run stopped at first error");
	endtask

	// rotation-mode CORDIC on 16-bit words with half-turn pre-rotation
	function automatic void cordic_model(input angle_t a, output trig_t s, output trig_t c);
		logic signed [15:0] x;
		logic signed [15:0] y;
		logic signed [15:0] z;
		logic signed [15:0] xs;
		logic signed [15:0] ys;
		int i;
		y = '0;
		if (a[15:14] == 2'b01 || a[15:14] == 2'b10) begin
			x = 16'(-GAIN_INV);
			z = a - 16'h8000;
		end else begin
			x = 16'(GAIN_INV);
			z = a;
		end
		for (i = 0; i < ITERS; i++) begin
			xs = x >>> i;
			ys = y >>> i;
			if (z >= 0) begin
				x = x - ys;
				y = y + xs;
				z = z - 16'(ATAN_REF[i]);
			end else begin
				x = x + ys;
				y = y - xs;
				z = z + 16'(ATAN_REF[i]);
			end
		end
		s = y;
		c = x;
	endfunction

	task automatic load_expected(input angle_t [NJ-1:0] th, input length_t [NJ-1:0] ln);
		angle_t    phase;
		trig_t     s;
		trig_t     c;
		longint    ps [NJ];
		longint    pc [NJ];
		longint    acc_s;
		longint    acc_c;
		jac_col_t  e;
		int        i;
		phase = '0;
		for (i = 0; i < NJ; i++) begin
			phase = phase + th[i]; // wraps at a full turn
			cordic_model(phase, s, c);
			ps[i] = (longint'(ln[i]) * longint'(s)) >>> 14;
			pc[i] = (longint'(ln[i]) * longint'(c)) >>> 14;
		end
		acc_s = 0;
		acc_c = 0;
		for (i = NJ - 1; i >= 0; i--) begin
			acc_s += ps[i];
			acc_c += pc[i];
			e.idx = joint_idx_t'(i);
			e.dx  = jac_t'(-acc_s);
			e.dy  = jac_t'(acc_c);
			exp_mem[wr_ptr] = e;
			wr_ptr = wr_ptr + 1'b1;
		end
	endtask

	// called and returns 1 unit after a rising edge
	task automatic run_job(input angle_t [NJ-1:0] th, input length_t [NJ-1:0] ln,
		input bit poke);
		logic seen;
		int   i;
		load_expected(th, ln);
		started  = 1'b1;
		start    = 1'b1;
		theta    = th;
		link_len = ln;
		@(posedge clk);
		#1;
		start = 1'b0;
		if (poke) begin
			repeat (5) @(posedge clk);
			#1;
			for (i = 0; i < NJ; i++) begin
				theta[i]    = ~th[i];
				link_len[i] = ln[i] ^ 16'h5a5a;
			end
			start = 1'b1; // lands while busy
			@(posedge clk);
			#1;
			start = 1'b0;
		end
		seen = 1'b0;
		while (!seen) begin
			@(posedge clk);
			#1;
			seen = done;
		end
		@(posedge clk);
		#1;
	endtask

	a_idle_quiet: assert property (@(posedge clk) disable iff (!rst_n)
		!started |-> (!busy && !col_valid && !done))
		else report_error("control output active before the first start");
	a_col_owed: assert property (@(posedge clk) disable iff (!rst_n)
		col_valid |-> (rd_ptr != wr_ptr))
		else report_error("column strobe with no column outstanding");
	a_col_value: assert property (@(posedge clk) disable iff (!rst_n)
		col_valid |-> (col == exp_head))
		else report_error($sformatf("col idx %0d dx %0d dy %0d, expected idx %0d dx %0d dy %0d",
			$sampled(col.idx), $sampled(col.dx), $sampled(col.dy),
			$sampled(exp_head.idx), $sampled(exp_head.dx), $sampled(exp_head.dy)));
	a_col_busy: assert property (@(posedge clk) disable iff (!rst_n)
		col_valid |-> busy)
		else report_error("column strobe while not busy");
	a_done_col0: assert property (@(posedge clk) disable iff (!rst_n)
		done |-> (col_valid && col.idx == '0))
		else report_error("done without the column 0 strobe");
	a_col0_done: assert property (@(posedge clk) disable iff (!rst_n)
		(col_valid && col.idx == '0) |-> done)
		else report_error("column 0 strobe without done");
	a_busy_fall: assert property (@(posedge clk) disable iff (!rst_n)
		done |=> !busy)
		else report_error("busy still high the cycle after done");
	a_busy_hold: assert property (@(posedge clk) disable iff (!rst_n)
		$fell(busy) |-> $past(done))
		else report_error("busy fell without done");
	a_busy_rise: assert property (@(posedge clk) disable iff (!rst_n)
		(start && !busy) |=> busy)
		else report_error("accepted start did not raise busy");

	initial begin
		angle_t  [NJ-1:0] th;
		length_t [NJ-1:0] ln;
		logic    [31:0]   r;
		int               i;
		int               j;
		seed      = 32'hefae;
		rst_n     = 1'b0;
		start     = 1'b0;
		theta     = '0;
		link_len  = '0;
		started   = 1'b0;
		wr_ptr    = '0;
		repeat (8) @(posedge clk);
		#1;
		rst_n = 1'b1;
		repeat (4) @(posedge clk); // idle outputs checked here
		#1;
		ln[0] = 16'h0100; // 1.0
		ln[1] = 16'h0280; // 2.5
		ln[2] = 16'h00c0; // 0.75
		th = '0;
		run_job(th, ln, 1'b0);
		th[0] = 16'h8000; // straddle the half turn
		th[1] = 16'h7fff;
		th[2] = 16'h8001;
		run_job(th, ln, 1'b0);
		th[0] = 16'hc000;
		th[1] = 16'hc000;
		th[2] = 16'hc000;
		run_job(th, ln, 1'b0);
		th[0] = 16'hf000;
		th[1] = 16'h2000; // sum wraps past a turn
		th[2] = 16'hbfff;
		for (i = 0; i < NJ; i++) begin
			r     = $random(seed);
			ln[i] = r[15:0];
		end
		run_job(th, ln, 1'b0);
		for (j = 4; j < NUM_JOBS; j++) begin
			for (i = 0; i < NJ; i++) begin
				r     = $random(seed);
				th[i] = r[15:0];
				ln[i] = r[31:16];
			end
			run_job(th, ln, (j % 4) == 0);
		end
		repeat (2 * NJ) @(posedge clk); // a late extra column still hits the checks
		#1;
		$display("PASS: all tests");
		$finish;
	end

endmodule

`default_nettype wire

// File: verification/clk_gen.sv
//----------------------------------------------------------------------------
// testbench clock source
//----------------------------------------------------------------------------
`default_nettype none

module clk_gen #(
	parameter int PERIOD = 8
) (
	output logic clk
);

	initial begin
		clk = 1'b0;
	end

	always #(PERIOD / 2) clk = ~clk; // half period high, half low

endmodule

`default_nettype wire

// File: src/planar_jacobian_top.sv
//----------------------------------------------------------------------------
// planar arm jacobian: phase producer, term FIFO, accumulator
//----------------------------------------------------------------------------
`default_nettype none

module planar_jacobian_top #(
	parameter int NUM_JOINTS = 3,
	parameter int FIFO_DEPTH = 2
) (
	input  logic                                    clk,
	input  logic                                    rst_n,
	input  logic                                    start,
	input  jacobian_pkg::angle_t [NUM_JOINTS-1:0]   theta,
	input  jacobian_pkg::length_t [NUM_JOINTS-1:0]  link_len,
	output logic                                    busy,
	output logic                                    col_valid,
	output jacobian_pkg::jac_col_t                  col,
	output logic                                    done
);

	import jacobian_pkg::*;

	logic        job_start;
	logic        push;
	logic        pop;
	logic        full;
	logic        empty;
	trig_term_t  term;
	trig_term_t  head;

	link_phase_unit #(
		.NUM_JOINTS (NUM_JOINTS)
	) u_phase (
		.clk       (clk),
		.rst_n     (rst_n),
		.start     (start),
		.theta     (theta),
		.full      (full),
		.busy      (busy),
		.job_start (job_start),
		.push      (push),
		.term      (term),
		.last_col  (done)      // busy ends with column 0
	);

	term_fifo #(
		.DEPTH (FIFO_DEPTH)
	) u_fifo (
		.clk     (clk),
		.rst_n   (rst_n),
		.push    (push),
		.pop     (pop),
		.term_in (term),
		.head    (head),
		.full    (full),
		.empty   (empty)
	);

	jacobian_accumulator #(
		.NUM_JOINTS (NUM_JOINTS)
	) u_acc (
		.clk       (clk),
		.rst_n     (rst_n),
		.job_start (job_start),
		.link_len  (link_len),
		.empty     (empty),
		.head      (head),
		.pop       (pop),
		.col_valid (col_valid),
		.done      (done),
		.col       (col)
	);

endmodule

`default_nettype wire

// File: src/jacobian_accumulator.sv
//----------------------------------------------------------------------------
// consumer: scales trig terms by link lengths, emits suffix-sum columns
//----------------------------------------------------------------------------
`default_nettype none

module jacobian_accumulator #(
	parameter int NUM_JOINTS = 3
) (
	input  logic                                    clk,
	input  logic                                    rst_n,
	input  logic                                    job_start,
	input  jacobian_pkg::length_t [NUM_JOINTS-1:0]  link_len,
	input  logic                                    empty,
	input  jacobian_pkg::trig_term_t                head,
	output logic                                    pop,
	output logic                                    col_valid,
	output logic                                    done,
	output jacobian_pkg::jac_col_t                  col
);

	import jacobian_pkg::*;

	typedef enum logic [1:0] {
		s_idle,
		s_scale_sin,
		s_scale_cos,
		s_emit
	} state_t;

	state_t                    state;
	length_t [NUM_JOINTS-1:0]  len_q;
	jac_t                      ps [NUM_JOINTS]; // scaled sines
	jac_t                      pc [NUM_JOINTS]; // scaled cosines
	joint_idx_t                k;               // column being emitted
	jac_t                      sum_s;
	jac_t                      sum_c;
	jac_t                      nxt_s;
	jac_t                      nxt_c;
	length_t                   mul_a;
	trig_t                     mul_b;
	logic signed [32:0]        prod;
	jac_t                      scaled;

	// single shared multiplier, sine first then cosine
	assign mul_a  = len_q[head.idx];
	assign mul_b  = (state == s_scale_cos) ? head.cos_v : head.sin_v;
	assign prod   = $signed({1'b0, mul_a}) * mul_b;
	assign scaled = jac_t'(prod >>> 14); // Q8.8

	assign pop = (state == s_scale_cos); // head consumed on cosine cycle

	assign nxt_s = sum_s + ps[k];
	assign nxt_c = sum_c + pc[k];

	assign col_valid = (state == s_emit);
	assign done      = (state == s_emit) && (k == '0);

	always_comb begin
		col     = '0;
		col.idx = k;
		col.dx  = -nxt_s;
		col.dy  = nxt_c;
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			state <= s_idle;
			k     <= '0;
		end else begin
			case (state)
				s_idle: begin
					if (job_start)
						state <= s_scale_sin;
				end
				s_scale_sin: begin
					if (!empty)
						state <= s_scale_cos;
				end
				s_scale_cos: begin
					if (head.last) begin
						state <= s_emit;
						k     <= joint_idx_t'(NUM_JOINTS - 1);
					end else begin
						state <= s_scale_sin;
					end
				end
				default: begin
					if (k == '0)
						state <= s_idle;
					else
						k <= k - 1'b1;
				end
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if (job_start)
			len_q <= link_len;
		if (state == s_scale_sin && !empty)
			ps[head.idx] <= scaled;
		if (state == s_scale_cos) begin
			pc[head.idx] <= scaled;
			sum_s        <= '0; // clear before the suffix walk
			sum_c        <= '0;
		end else if (state == s_emit) begin
			sum_s <= nxt_s;
			sum_c <= nxt_c;
		end
	end

endmodule

`default_nettype wire

// File: src/term_fifo.sv
//----------------------------------------------------------------------------
// synchronous first-word-fall-through FIFO of trig terms
//----------------------------------------------------------------------------
`default_nettype none

module term_fifo #(
	parameter int DEPTH = 2
) (
	input  logic                      clk,
	input  logic                      rst_n,
	input  logic                      push,
	input  logic                      pop,
	input  jacobian_pkg::trig_term_t  term_in,
	output jacobian_pkg::trig_term_t  head,
	output logic                      full,
	output logic                      empty
);

	import jacobian_pkg::*;

	localparam int AW = (DEPTH > 1) ? $clog2(DEPTH) : 1;
	localparam int CW = $clog2(DEPTH + 1);

	trig_term_t     mem [DEPTH];
	logic [AW-1:0]  wptr;
	logic [AW-1:0]  rptr;
	logic [CW-1:0]  count;
	logic           wr_en;
	logic           rd_en;

	assign wr_en = push && !full;
	assign rd_en = pop && !empty;

	assign full  = (count == CW'(DEPTH));
	assign empty = (count == '0);
	assign head  = mem[rptr]; // valid whenever not empty

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			wptr  <= '0;
			rptr  <= '0;
			count <= '0;
		end else begin
			if (wr_en)
				wptr <= (wptr == AW'(DEPTH - 1)) ? '0 : wptr + 1'b1;
			if (rd_en)
				rptr <= (rptr == AW'(DEPTH - 1)) ? '0 : rptr + 1'b1;
			if (wr_en && !rd_en)
				count <= count + 1'b1;
			else if (rd_en && !wr_en)
				count <= count - 1'b1;
		end
	end

	always_ff @(posedge clk) begin
		if (wr_en)
			mem[wptr] <= term_in;
	end

endmodule

`default_nettype wire

// File: src/link_phase_unit.sv
//----------------------------------------------------------------------------
// producer: cumulative link angles, one CORDIC per link, trig term push
//----------------------------------------------------------------------------
`default_nettype none

module link_phase_unit #(
	parameter int NUM_JOINTS = 3
) (
	input  logic                                    clk,
	input  logic                                    rst_n,
	input  logic                                    start,
	input  jacobian_pkg::angle_t [NUM_JOINTS-1:0]   theta,
	input  logic                                    full,
	output logic                                    busy,
	output logic                                    job_start,
	output logic                                    push,
	output jacobian_pkg::trig_term_t                term,
	input  logic                                    last_col
);

	import jacobian_pkg::*;

	typedef enum logic [1:0] {
		s_idle,
		s_accumulate,
		s_rotate,
		s_emit
	} state_t;

	state_t                   state;
	angle_t [NUM_JOINTS-1:0]  theta_q;
	angle_t                   phase;   // running link angle
	joint_idx_t               idx;
	logic                     go;
	logic                     ready;
	trig_t                    sin_w;
	trig_t                    cos_w;
	logic                     is_last;

	assign job_start = start && !busy;
	assign is_last   = (idx == joint_idx_t'(NUM_JOINTS - 1));
	assign push      = (state == s_emit) && !full;

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			state <= s_idle;
			busy  <= 1'b0;
			go    <= 1'b0;
			idx   <= '0;
		end else begin
			go <= (state == s_accumulate); // pulse on first rotate cycle
			if (job_start)
				busy <= 1'b1;
			else if (last_col)
				busy <= 1'b0; // consumer emitted column 0
			case (state)
				s_idle: begin
					if (job_start) begin
						state <= s_accumulate;
						idx   <= '0;
					end
				end
				s_accumulate: state <= s_rotate;
				s_rotate: begin
					if (ready)
						state <= s_emit;
				end
				default: begin
					if (push) begin
						if (is_last) begin
							state <= s_idle;
						end else begin
							idx   <= idx + 1'b1;
							state <= s_accumulate;
						end
					end
				end
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if (job_start) begin
			theta_q <= theta;
			phase   <= '0;
		end else if (state == s_accumulate) begin
			phase <= phase + theta_q[idx]; // wraps modulo a turn
		end
	end

	cordic_sincos #(
		.ITERS (CORDIC_ITERS)
	) u_cordic (
		.clk   (clk),
		.rst_n (rst_n),
		.go    (go),
		.angle (phase),
		.ready (ready),
		.sin_v (sin_w),
		.cos_v (cos_w)
	);

	// cordic outputs hold until the next go
	always_comb begin
		term       = '0;
		term.idx   = idx;
		term.last  = is_last;
		term.sin_v = sin_w;
		term.cos_v = cos_w;
	end

endmodule

`default_nettype wire

// File: src/cordic_sincos.sv
//----------------------------------------------------------------------------
// iterative rotation-mode CORDIC, sine and cosine of one binary angle
//----------------------------------------------------------------------------
`default_nettype none

module cordic_sincos #(
	parameter int ITERS = jacobian_pkg::CORDIC_ITERS
) (
	input  logic                  clk,
	input  logic                  rst_n,
	input  logic                  go,
	input  jacobian_pkg::angle_t  angle,
	output logic                  ready,
	output jacobian_pkg::trig_t   sin_v,
	output jacobian_pkg::trig_t   cos_v
);

	import jacobian_pkg::*;

	localparam int IW = $clog2(ITERS);

	typedef enum logic [1:0] {
		s_idle,
		s_iterate,
		s_finish
	} state_t;

	state_t          state;
	logic [IW-1:0]   it;    // iteration index
	trig_t           x;
	trig_t           y;
	logic signed [15:0] z;  // residual angle
	trig_t           x_sh;
	trig_t           y_sh;
	logic            left_half;

	assign left_half = angle[15] ^ angle[14]; // quadrants 1 and 2

	assign x_sh = x >>> it;
	assign y_sh = y >>> it;

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			state <= s_idle;
			it    <= '0;
		end else begin
			case (state)
				s_idle: begin
					if (go) begin
						state <= s_iterate;
						it    <= '0;
					end
				end
				s_iterate: begin
					if (it == IW'(ITERS - 1))
						state <= s_finish;
					else
						it <= it + 1'b1;
				end
				default: state <= s_idle; // finish lasts one cycle
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if (state == s_idle && go) begin
			y <= '0;
			if (left_half) begin
				// pre-rotate by half a turn
				x <= -CORDIC_GAIN_INV;
				z <= angle - 16'h8000;
			end else begin
				x <= CORDIC_GAIN_INV;
				z <= angle;
			end
		end else if (state == s_iterate) begin
			if (!z[15]) begin
				x <= x - y_sh;
				y <= y + x_sh;
				z <= z - CORDIC_ATAN[it];
			end else begin
				x <= x + y_sh;
				y <= y - x_sh;
				z <= z + CORDIC_ATAN[it];
			end
		end
	end

	assign ready = (state == s_finish);
	assign sin_v = y;
	assign cos_v = x;

endmodule

`default_nettype wire

// File: src/jacobian_pkg.sv
//----------------------------------------------------------------------------
// fixed-point widths, buffer and column structs, CORDIC constants
//----------------------------------------------------------------------------
`default_nettype none

package jacobian_pkg;

	// binary angle, a full turn is 2^16
	typedef logic [15:0] angle_t;

	// sine or cosine, Q1.14
	typedef logic signed [15:0] trig_t;

	// link length, unsigned Q8.8
	typedef logic [15:0] length_t;

	// jacobian entry, Q8.8
	typedef logic signed [23:0] jac_t;

	typedef logic [1:0] joint_idx_t; // up to 4 joints

	// one trig term per link, producer to consumer
	typedef struct packed {
		joint_idx_t idx;
		logic       last; // final link of the job
		trig_t      sin_v;
		trig_t      cos_v;
	} trig_term_t;

	// one output column
	typedef struct packed {
		joint_idx_t idx;
		jac_t       dx;
		jac_t       dy;
	} jac_col_t;

	localparam int CORDIC_ITERS = 14;

	localparam trig_t CORDIC_GAIN_INV = 16'sd9949; // 0.60725

	// atan(2^-i) in binary-angle units
	localparam angle_t CORDIC_ATAN [0:13] = '{
		16'd8192, 16'd4836, 16'd2555, 16'd1297,
		16'd651,  16'd326,  16'd163,  16'd81,
		16'd41,   16'd20,   16'd10,   16'd5,
		16'd3,    16'd1
	};

endpackage

`default_nettype wire
